/* hw/skein_settings.svh */
`ifndef SKEIN_SETTINGS_SVH
`define SKEIN_SETTINGS_SVH

// Width of one Skein-1024 state word
`define SKEIN_WORD_BITS 64

// Words per 1024-bit block, and key words including the parity word
`define SKEIN_STATE_WORDS 16
`define SKEIN_KEY_WORDS 17

// The message occupies the low words and the nonce sits right above it
`define SKEIN_MSG_WORDS 10
`define SKEIN_NONCE_WORD 10

// Number of registered subkey-injection stages
`define SKEIN_INJECTIONS 4

// Key-schedule parity constant
`define SKEIN_KS_PARITY 64'h5555555555555555

`endif

/* hw/skeinPkg.sv */
`include "skein_settings.svh"

package skeinPkg;

	typedef logic [`SKEIN_WORD_BITS-1:0] wordT;
	typedef wordT [`SKEIN_STATE_WORDS-1:0] stateT;
	typedef wordT [`SKEIN_KEY_WORDS-1:0] keyT;
	typedef wordT [2:0] tweakT;
	typedef wordT [`SKEIN_MSG_WORDS-1:0] msgT;

	// Configuration port opcodes
	typedef enum logic [1:0] {
		cfgKey = 2'd0,
		cfgTweak = 2'd1,
		cfgNonce = 2'd2
	} cfgOpT;

	// Parity word of the key schedule over sixteen words
	function automatic wordT parityOf(stateT words);
		wordT acc;
		acc = `SKEIN_KS_PARITY;
		for (int i = 0; i < `SKEIN_STATE_WORDS; i++)
		begin
			acc ^= words[i];
		end
		return acc;
	endfunction

	// The input block holds the message words, then the nonce, with zeros above
	function automatic stateT buildBlock(msgT msg, wordT nonce);
		stateT blk;
		blk = '0;
		for (int i = 0; i < `SKEIN_MSG_WORDS; i++)
		begin
			blk[i] = msg[i];
		end
		blk[`SKEIN_NONCE_WORD] = nonce;
		return blk;
	endfunction

endpackage

/* hw/skeinKeyConfig.sv */
`timescale 1ns/1ps
`include "skein_settings.svh"

module skeinKeyConfig import skeinPkg::*;
(
	input logic clk,
	input logic arstN,
	input logic cfgWrite,
	input cfgOpT cfgOp,
	input logic [3:0] cfgIndex,
	input wordT cfgData,
	output keyT keySched,
	output tweakT tweakSched,
	output wordT nonceStart
);

	// Stored key and tweak words as written through the port
	stateT keyWords;
	wordT [1:0] tweakWords;

	// Register contents after the current write, if any
	stateT keyNext;
	wordT [1:0] tweakNext;
	wordT nonceNext;

	// Derived words change in step with the words they come from
	wordT parityReg;
	wordT tweakMix;

	always_comb
	begin
		keyNext = keyWords;
		tweakNext = tweakWords;
		nonceNext = nonceStart;
		if (cfgWrite)
		begin
			case (cfgOp)
				cfgKey:
				begin
					keyNext[cfgIndex] = cfgData;
				end
				cfgTweak:
				begin
					// Only tweak words 0 and 1 are writable
					tweakNext[cfgIndex[0]] = cfgData;
				end
				cfgNonce:
				begin
					nonceNext = cfgData;
				end
				default:
				begin
					keyNext = keyWords;
				end
			endcase
		end
	end

	// The parity and third tweak word are computed from the next values, so
	// they change on the same edge as the write that affects them
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			keyWords <= '0;
			tweakWords <= '0;
			nonceStart <= '0;
			parityReg <= `SKEIN_KS_PARITY;
			tweakMix <= '0;
		end
		else
		begin
			keyWords <= keyNext;
			tweakWords <= tweakNext;
			nonceStart <= nonceNext;
			parityReg <= parityOf(keyNext);
			tweakMix <= tweakNext[0] ^ tweakNext[1];
		end
	end

	// Word 16 of the key schedule is the parity, word 2 of the tweak the mix
	assign keySched = {parityReg, keyWords};
	assign tweakSched = {tweakMix, tweakWords[1], tweakWords[0]};

endmodule

/* hw/skeinNonceGen.sv */
`timescale 1ns/1ps
`include "skein_settings.svh"

module skeinNonceGen import skeinPkg::*;
#(
	parameter int hashers = 1
)
(
	input logic clk,
	input logic arstN,
	input logic run,
	input msgT msgWords,
	input wordT nonceStart,
	output logic blkValid,
	output stateT blkState,
	output wordT nonce
);

	localparam int drainBits = $clog2(`SKEIN_INJECTIONS + 1);

	// Cycles left until the last accepted block has reached the output stage
	logic [drainBits-1:0] drainCount;
	logic stepping;

	// The output stage recovers each block's nonce from this counter, so it
	// keeps stepping until the pipeline has drained and only then reloads
	assign stepping = run || (drainCount != '0);

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			blkValid <= 1'b0;
			drainCount <= '0;
			nonce <= '0;
		end
		else
		begin
			blkValid <= run;
			if (run)
			begin
				drainCount <= drainBits'(`SKEIN_INJECTIONS);
			end
			else if (drainCount != '0)
			begin
				drainCount <= drainCount - 1'b1;
			end
			if (stepping)
			begin
				nonce <= nonce + wordT'(hashers);
			end
			else
			begin
				nonce <= nonceStart;
			end
		end
	end

	// Block k of a run carries nonceStart + k * hashers
	always_ff @(posedge clk)
	begin
		if (run)
		begin
			blkState <= buildBlock(msgWords, nonce);
		end
	end

endmodule

/* hw/skeinSubkeyInject.sv */
`timescale 1ns/1ps
`include "skein_settings.svh"

module skeinSubkeyInject import skeinPkg::*;
#(
	parameter int injectionIdx = 0
)
(
	input logic clk,
	input logic arstN,
	input logic inValid,
	input stateT inState,
	input keyT keySched,
	input tweakT tweakSched,
	output logic outValid,
	output stateT outState
);

	// Tweak words for words 13 and 14 are picked by injection number mod 3
	localparam int tweakLo = injectionIdx % 3;
	localparam int tweakHi = (injectionIdx + 1) % 3;

	// The injection number itself is added into the top word
	localparam wordT injWord = wordT'(injectionIdx);

	stateT keyAdd;
	stateT sum;

	// Key words rotate by one position per injection and all indices are
	// constant after elaboration, so this is plain wiring
	always_comb
	begin
		for (int i = 0; i < `SKEIN_STATE_WORDS; i++)
		begin
			keyAdd[i] = keySched[(injectionIdx + i) % `SKEIN_KEY_WORDS];
		end
	end

	always_comb
	begin
		for (int i = 0; i < `SKEIN_STATE_WORDS; i++)
		begin
			sum[i] = inState[i] + keyAdd[i];
		end
		sum[13] = inState[13] + keyAdd[13] + tweakSched[tweakLo];
		sum[14] = inState[14] + keyAdd[14] + tweakSched[tweakHi];
		sum[15] = inState[15] + keyAdd[15] + injWord;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (inValid)
		begin
			outState <= sum;
		end
	end

endmodule

/* hw/skeinChainOut.sv */
`timescale 1ns/1ps
`include "skein_settings.svh"

module skeinChainOut import skeinPkg::*;
#(
	parameter int hashers = 1
)
(
	input logic clk,
	input logic arstN,
	input logic inValid,
	input stateT inState,
	input msgT msgWords,
	input wordT nonce,
	output logic outValid,
	output keyT chainKey
);

	// By the time a block leaves the last injection stage the nonce counter
	// has moved on by one step per stage plus the input register
	localparam wordT rewind = wordT'(hashers * (`SKEIN_INJECTIONS + 1));

	stateT inBlock;
	stateT ffState;

	assign inBlock = buildBlock(msgWords, nonce - rewind);

	// Feed-forward of the original block into the final state
	assign ffState = inState ^ inBlock;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= inValid;
		end
	end

	// The chaining key is extended with its own parity word
	always_ff @(posedge clk)
	begin
		if (inValid)
		begin
			chainKey <= {parityOf(ffState), ffState};
		end
	end

endmodule

/* hw/skeinFirstBlock.sv */
`timescale 1ns/1ps
`include "skein_settings.svh"

module skeinFirstBlock import skeinPkg::*;
#(
	parameter int hashers = 1
)
(
	input logic clk,
	input logic arstN,
	input logic cfgWrite,
	input cfgOpT cfgOp,
	input logic [3:0] cfgIndex,
	input wordT cfgData,
	input logic run,
	input msgT msgWords,
	output logic outValid,
	output keyT chainKey
);

	keyT keySched;
	tweakT tweakSched;
	wordT nonceStart;
	wordT nonce;

	// Entry s of the chain feeds injection stage s
	logic [`SKEIN_INJECTIONS:0] stageValid;
	stateT stageState [`SKEIN_INJECTIONS+1];

	skeinKeyConfig keyConfig_i (
		.clk(clk),
		.arstN(arstN),
		.cfgWrite(cfgWrite),
		.cfgOp(cfgOp),
		.cfgIndex(cfgIndex),
		.cfgData(cfgData),
		.keySched(keySched),
		.tweakSched(tweakSched),
		.nonceStart(nonceStart)
	);

	skeinNonceGen #(.hashers(hashers)) nonceGen_i (
		.clk(clk),
		.arstN(arstN),
		.run(run),
		.msgWords(msgWords),
		.nonceStart(nonceStart),
		.blkValid(stageValid[0]),
		.blkState(stageState[0]),
		.nonce(nonce)
	);

	for (genvar s = 0; s < `SKEIN_INJECTIONS; s++)
	begin : injectChain
		skeinSubkeyInject #(.injectionIdx(s)) inject_i (
			.clk(clk),
			.arstN(arstN),
			.inValid(stageValid[s]),
			.inState(stageState[s]),
			.keySched(keySched),
			.tweakSched(tweakSched),
			.outValid(stageValid[s+1]),
			.outState(stageState[s+1])
		);
	end

	skeinChainOut #(.hashers(hashers)) chainOut_i (
		.clk(clk),
		.arstN(arstN),
		.inValid(stageValid[`SKEIN_INJECTIONS]),
		.inState(stageState[`SKEIN_INJECTIONS]),
		.msgWords(msgWords),
		.nonce(nonce),
		.outValid(outValid),
		.chainKey(chainKey)
	);

endmodule

/* bench/skeinFirstBlock_asserts.sv */
`timescale 1ns/1ps
`include "skein_settings.svh"

module skeinFirstBlockAsserts import skeinPkg::*;
#(
	parameter int hashers = 1
)
(
	input logic clk,
	input logic arstN,
	input logic cfgWrite,
	input cfgOpT cfgOp,
	input logic [3:0] cfgIndex,
	input wordT cfgData,
	input logic run,
	input msgT msgWords,
	input logic outValid,
	input keyT chainKey
);

	localparam int latency = `SKEIN_INJECTIONS + 2;

	int errorCount = 0;

	// Shadow of everything written through the configuration port
	stateT shadowKey;
	wordT [1:0] shadowTweak;
	wordT shadowStart;

	logic runPrev;
	logic [latency-2:0] runHist;
	wordT expNonce;
	wordT nonceNow;
	keyT expPipe [latency];

	function automatic wordT foldParity(stateT w);
		wordT acc;
		acc = `SKEIN_KS_PARITY;
		for (int i = 0; i < `SKEIN_STATE_WORDS; i++)
		begin
			acc ^= w[i];
		end
		return acc;
	endfunction

	// Expected chaining key for one block from the injection and output rules
	function automatic keyT modelOutput(msgT msg, wordT n, stateT key, wordT [1:0] tw);
		keyT ks;
		tweakT ts;
		stateT blk;
		stateT st;
		ks = {foldParity(key), key};
		ts = {tw[0] ^ tw[1], tw[1], tw[0]};
		blk = '0;
		blk[`SKEIN_MSG_WORDS-1:0] = msg;
		blk[`SKEIN_NONCE_WORD] = n;
		st = blk;
		for (int s = 0; s < `SKEIN_INJECTIONS; s++)
		begin
			for (int i = 0; i < `SKEIN_STATE_WORDS; i++)
			begin
				st[i] += ks[(s + i) % `SKEIN_KEY_WORDS];
			end
			st[13] += ts[s % 3];
			st[14] += ts[(s + 1) % 3];
			st[15] += wordT'(s);
		end
		st ^= blk;
		return {foldParity(st), st};
	endfunction

	// Block k of a run carries the start value plus k strides
	assign nonceNow = runPrev ? expNonce + wordT'(hashers) : shadowStart;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			shadowKey <= '0;
			shadowTweak <= '0;
			shadowStart <= '0;
			runPrev <= 1'b0;
			runHist <= '0;
			expNonce <= '0;
		end
		else
		begin
			runPrev <= run;
			runHist <= {runHist[latency-3:0], run};
			if (run)
			begin
				expNonce <= nonceNow;
			end
			if (cfgWrite && cfgOp == cfgKey)
			begin
				shadowKey[cfgIndex] <= cfgData;
			end
			if (cfgWrite && cfgOp == cfgTweak)
			begin
				shadowTweak[cfgIndex[0]] <= cfgData;
			end
			if (cfgWrite && cfgOp == cfgNonce)
			begin
				shadowStart <= cfgData;
			end
		end
	end

	// Expected results travel alongside the DUT pipeline
	always_ff @(posedge clk)
	begin
		expPipe[0] <= modelOutput(msgWords, nonceNow, shadowKey, shadowTweak);
		for (int k = 1; k < latency; k++)
		begin
			expPipe[k] <= expPipe[k-1];
		end
	end

	validFollowsRun: assert property (@(posedge clk) disable iff (!arstN)
		run |-> ##latency outValid)
	else
	begin
		errorCount++;
		$error("outValid did not rise %0d cycles after a run sample", latency);
	end

	noSpuriousValid: assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> $past(run, latency))
	else
	begin
		errorCount++;
		$error("outValid rose without a run sample %0d cycles before", latency);
	end

	cfgOnlyWhenIdle: assert property (@(posedge clk) disable iff (!arstN)
		cfgWrite |-> !run && !(|runHist))
	else
	begin
		errorCount++;
		$error("Configuration write while a run is active or outputs are pending");
	end

	// Word 16 of the model is the parity over the model's words 0 to 15
	for (genvar w = 0; w < `SKEIN_KEY_WORDS; w++)
	begin : wordCheck
		chainWordOk: assert property (@(posedge clk) disable iff (!arstN)
			outValid |-> chainKey[w] == expPipe[latency-1][w])
		else
		begin
			errorCount++;
			$error("Fail at %0t: chainKey[%0d] is %h, expected %h", $time, w,
				$sampled(chainKey[w]), $sampled(expPipe[latency-1][w]));
		end
	end

endmodule

bind skeinFirstBlock skeinFirstBlockAsserts #(.hashers(hashers)) asserts_i (.*);

/* bench/skeinFirstBlockTb.sv */
`timescale 1ns/1ps
`include "skein_settings.svh"

module skeinFirstBlockTb import skeinPkg::*;
();

	localparam int latency = `SKEIN_INJECTIONS + 2;
	localparam int resetCycles = 8;
	localparam int idleCycles = 10;
	localparam int fullConfig = `SKEIN_STATE_WORDS + 3;
	localparam int burstLen = 10;
	localparam int rerunLen = 3;
	// Each run is counted with its config writes, latency and a few spare cycles
	localparam int testCycles = resetCycles + idleCycles + (fullConfig + 4 + latency + 4)
		+ (burstLen + 2 + latency + 4) + (4 + 3 + rerunLen + latency + 4);
	localparam int maxCycles = 2 * testCycles;

	logic clk;
	logic arstN;
	logic cfgWrite;
	cfgOpT cfgOp;
	logic [3:0] cfgIndex;
	wordT cfgData;
	logic run;
	msgT msgWords;
	logic outValid;
	keyT chainKey;

	int cycleCount = 0;
	int outCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int errorsBefore = 0;

	skeinFirstBlock skeinFirstBlock_i (
		.clk(clk),
		.arstN(arstN),
		.cfgWrite(cfgWrite),
		.cfgOp(cfgOp),
		.cfgIndex(cfgIndex),
		.cfgData(cfgData),
		.run(run),
		.msgWords(msgWords),
		.outValid(outValid),
		.chainKey(chainKey)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Outputs are counted on the falling edge, half a cycle after they change
	always @(negedge clk)
	begin
		if (outValid)
		begin
			outCount++;
		end
	end

	initial
	begin
		while (cycleCount < maxCycles)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", maxCycles);
		$display("ERRORS FOUND");
		$finish;
	end

	function automatic wordT randomWord();
		return {$urandom, $urandom};
	endfunction

	function automatic msgT randomMsg();
		msgT m;
		for (int i = 0; i < `SKEIN_MSG_WORDS; i++)
		begin
			m[i] = randomWord();
		end
		return m;
	endfunction

	// Back to back calls keep cfgWrite high and write one word per cycle
	task automatic writeConfig(input cfgOpT op, input logic [3:0] idx, input wordT data);
		@(posedge clk);
		cfgWrite <= 1'b1;
		cfgOp <= op;
		cfgIndex <= idx;
		cfgData <= data;
	endtask

	task automatic stopConfig();
		@(posedge clk);
		cfgWrite <= 1'b0;
	endtask

	task automatic runBlocks(input int count, input msgT msg);
		@(posedge clk);
		msgWords <= msg;
		repeat (count)
		begin
			@(posedge clk);
			run <= 1'b1;
		end
		@(posedge clk);
		run <= 1'b0;
	endtask

	// The output count settles at the falling edge, so it is read on the rising one
	task automatic waitOutputs(input int target);
		while (outCount < target)
		begin
			@(posedge clk);
		end
	endtask

	task automatic startTest();
		errorsBefore = skeinFirstBlock_i.asserts_i.errorCount;
	endtask

	// The assertions sample the last output one edge later, so give them time
	task automatic endTest(input string name);
		repeat (2) @(negedge clk);
		testsRun++;
		if (skeinFirstBlock_i.asserts_i.errorCount != errorsBefore)
		begin
			testsFailed++;
			$display("test %s: failed", name);
		end
		else
		begin
			$display("test %s: passed", name);
		end
	endtask

	initial
	begin
		void'($urandom(32'h15be));
		arstN = 1'b0;
		cfgWrite = 1'b0;
		cfgOp = cfgKey;
		cfgIndex = '0;
		cfgData = '0;
		run = 1'b0;
		msgWords = '0;
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;

		startTest();
		repeat (idleCycles) @(posedge clk);
		endTest("idle after reset");

		startTest();
		for (int i = 0; i < `SKEIN_STATE_WORDS; i++)
		begin
			writeConfig(cfgKey, 4'(i), randomWord());
		end
		writeConfig(cfgTweak, 4'd0, randomWord());
		writeConfig(cfgTweak, 4'd1, randomWord());
		writeConfig(cfgNonce, 4'd0, randomWord());
		stopConfig();
		runBlocks(1, randomMsg());
		waitOutputs(1);
		endTest("single block");

		startTest();
		runBlocks(burstLen, randomMsg());
		waitOutputs(1 + burstLen);
		endTest("burst of ten");

		startTest();
		writeConfig(cfgKey, 4'($urandom_range(15)), randomWord());
		writeConfig(cfgTweak, 4'd0, randomWord());
		writeConfig(cfgTweak, 4'd1, randomWord());
		writeConfig(cfgNonce, 4'd0, randomWord());
		stopConfig();
		runBlocks(rerunLen, randomMsg());
		waitOutputs(1 + burstLen + rerunLen);
		endTest("reconfigure and rerun");

		$display("tests run %0d, tests failed %0d, assertion errors %0d", testsRun, testsFailed,
			skeinFirstBlock_i.asserts_i.errorCount);
		if (testsFailed == 0 && skeinFirstBlock_i.asserts_i.errorCount == 0)
		begin
			$display("NO ERRORS");
		end
		else
		begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+hw
hw/skeinPkg.sv
hw/skeinKeyConfig.sv
hw/skeinNonceGen.sv
hw/skeinSubkeyInject.sv
hw/skeinChainOut.sv
hw/skeinFirstBlock.sv
bench/skeinFirstBlock_asserts.sv
bench/skeinFirstBlockTb.sv

/* Bender.yml */
package:
  name: skein_first_block

sources:
  - include_dirs:
      - hw
    files:
      - hw/skeinPkg.sv
      - hw/skeinKeyConfig.sv
      - hw/skeinNonceGen.sv
      - hw/skeinSubkeyInject.sv
      - hw/skeinChainOut.sv
      - hw/skeinFirstBlock.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/skeinFirstBlock_asserts.sv
      - bench/skeinFirstBlockTb.sv
